// File: bench/video_patterns.hex
// One RGB444 pixel per line as three hex digits: red, green, blue.
// 64 pixels in raster order, two frames of the 8x4 tiny mode.
115
125
135
145
155
165
175
185
215
225
235
245
255
265
275
285
315
325
335
345
355
365
375
385
415
425
435
445
455
465
475
485
51a
52a
53a
54a
55a
56a
57a
58a
61a
62a
63a
64a
65a
66a
67a
68a
71a
72a
73a
74a
75a
76a
77a
78a
81a
82a
83a
84a
85a
86a
87a
88a

// File: filelist.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/pixel_buffer.sv
verilog/video_ctrl.sv
verilog/pixel_out.sv
verilog/video_top.sv
bench/video_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the video testbench with Verilator and runs it from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -sv \
    --top-module video_tb \
    -f filelist.f \
    -Mdir obj_dir \
    -o video_sim

./obj_dir/video_sim | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "Simulation passed."
    exit 0
fi

echo "Simulation failed, see sim.log."
exit 1

// File: bench/video_tb.sv
`timescale 1ns/1ns

module video_tb;

    import video_pkg::*;

    // Tiny raster of 16 clocks per line and 8 lines per frame.
    localparam int H_ACTIVE     = 8;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 3;
    localparam int V_ACTIVE     = 4;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int BUF_DEPTH    = 8;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int NUM_PIXELS   = 64;
    localparam int STALL_IDX    = 40;  // Falls in the second frame.
    localparam int STALL_CYCLES = 12;
    localparam int MAX_CYCLES   = 1000;

    logic        clk;
    logic        rst;
    logic        px_valid;
    pixel_t      px_data;
    logic        px_credit;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        vga_hsync;
    logic        vga_vsync;
    logic [15:0] underrun_count;

    logic [11:0] patterns [NUM_PIXELS];
    int          pending[$];  // Pattern indices held in the DUT buffer.
    integer      seed;
    int          mh;
    int          mv;
    int          cyc;
    int          shown;
    int          exp_under;
    int          credits;
    int          total_credits;
    int          early_credits;
    int          next_idx;
    int          sent_idx;
    bit          sent;
    int          stall_left;
    bit          stall_done;
    int          stall_model_base;
    logic [15:0] stall_dut_base;
    bit          timed_out;
    int          checks;
    int          errors;

    video_top #(
        .H_ACTIVE  (H_ACTIVE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_ACTIVE  (V_ACTIVE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK),
        .BUF_DEPTH (BUF_DEPTH)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .px_valid       (px_valid),
        .px_data        (px_data),
        .px_credit      (px_credit),
        .vga_r          (vga_r),
        .vga_g          (vga_g),
        .vga_b          (vga_b),
        .vga_hsync      (vga_hsync),
        .vga_vsync      (vga_vsync),
        .underrun_count (underrun_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                     name, actual, expected, cyc);
            errors++;
        end
    endtask

    function automatic bit in_window(int cnt, int start, int len);
        return (cnt >= start) && (cnt < start + len);
    endfunction

    task automatic check_reset_state();
        compare_value("vga_r", 32'(vga_r), 32'h0);
        compare_value("vga_g", 32'(vga_g), 32'h0);
        compare_value("vga_b", 32'(vga_b), 32'h0);
        compare_value("vga_hsync", 32'(vga_hsync), 32'h0);
        compare_value("vga_vsync", 32'(vga_vsync), 32'h0);
        compare_value("underrun_count", 32'(underrun_count), 32'h0);
        compare_value("px_credit", 32'(px_credit), 32'h0);
    endtask

    // One clock of the model. The outputs seen at this falling edge belong
    // to the raster position (mh, mv) that the rising edge just consumed.
    task automatic run_cycle();
        logic [31:0] rnd;
        logic [11:0] exp_px;
        bit          active;
        @(negedge clk);
        cyc++;
        active = (mh < H_ACTIVE) && (mv < V_ACTIVE);
        exp_px = '0;
        if (active) begin
            if (pending.size() > 0) begin
                exp_px = patterns[pending.pop_front()];
                shown++;
            end else begin
                exp_under++;  // Buffer was dry at this position.
            end
        end
        if (sent) begin
            pending.push_back(sent_idx);  // Written on the same edge but after the pop.
        end
        compare_value("vga_r", 32'(vga_r), 32'(exp_px[11:8]));
        compare_value("vga_g", 32'(vga_g), 32'(exp_px[7:4]));
        compare_value("vga_b", 32'(vga_b), 32'(exp_px[3:0]));
        compare_value("vga_hsync", 32'(vga_hsync),
                      32'(in_window(mh, H_ACTIVE + H_FRONT, H_SYNC)));
        compare_value("vga_vsync", 32'(vga_vsync),
                      32'(in_window(mv, V_ACTIVE + V_FRONT, V_SYNC)));
        compare_value("underrun_count", 32'(underrun_count), 32'(exp_under));

        if (mh == H_TOTAL - 1) begin
            mh = 0;
            mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
        end else begin
            mh++;
        end

        if (px_credit) begin
            credits++;
            total_credits++;
            if (cyc <= BUF_DEPTH) begin
                early_credits++;
            end
        end
        if (credits > BUF_DEPTH) begin
            $display("Source credit count above the buffer depth: %0d at cycle %0d",
                     credits, cyc);
            errors++;
        end

        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
                compare_value("underrun_count rise during stall",
                              32'(underrun_count - stall_dut_base),
                              32'(exp_under - stall_model_base));
            end
        end else if (!stall_done && next_idx == STALL_IDX) begin
            stall_left       = STALL_CYCLES;
            stall_done       = 1'b1;
            stall_model_base = exp_under;
            stall_dut_base   = underrun_count;
        end

        rnd  = $random(seed);
        sent = 1'b0;
        if (stall_left == 0 && credits > 0 && next_idx < NUM_PIXELS && rnd[1:0] != 2'b00) begin
            px_valid = 1'b1;
            px_data  = patterns[next_idx];
            sent_idx = next_idx;
            sent     = 1'b1;
            next_idx++;
            credits--;
        end else begin
            px_valid = 1'b0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst      = 1'b1;
        px_valid = 1'b0;
        px_data  = '0;
        seed     = 32'he41c_340f;
        $readmemh("bench/video_patterns.hex", patterns);
        if ($isunknown(patterns[NUM_PIXELS-1]) || patterns[NUM_PIXELS-1] == 12'h000) begin
            $display("Pattern file did not load completely.");
            errors++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        rst = 1'b0;
        #1;
        check_reset_state();  // Nothing moves before the first rising edge.

        while (shown < NUM_PIXELS && !timed_out) begin
            if (cyc >= MAX_CYCLES) begin
                $display("Timed out waiting for all pattern pixels to be shown.");
                timed_out = 1'b1;
                errors++;
            end else begin
                run_cycle();
            end
        end

        if (!timed_out) begin
            run_cycle();  // The last pop returns its credit one clock later.
            compare_value("initial credits", 32'(early_credits), 32'(BUF_DEPTH));
            compare_value("total credits", 32'(total_credits), 32'(BUF_DEPTH + shown));
            if (!stall_done || stall_left != 0) begin
                $display("The source stall in frame 2 never completed.");
                errors++;
            end
        end

        $display("checks: %0d, errors: %0d, underruns: %0d", checks, errors, exp_under);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog/video_top.sv
`timescale 1ns/1ns

module video_top #(
    parameter int H_ACTIVE  = video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT   = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC    = video_pkg::DEF_H_SYNC,
    parameter int H_BACK    = video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE  = video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT   = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC    = video_pkg::DEF_V_SYNC,
    parameter int V_BACK    = video_pkg::DEF_V_BACK,
    parameter int BUF_DEPTH = video_pkg::DEF_BUF_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              px_valid,
    input  video_pkg::pixel_t px_data,
    output logic              px_credit,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic [15:0]       underrun_count
);

    import video_pkg::*;

    logic   pixel_active;
    logic   hsync_d;
    logic   vsync_d;
    logic   buf_pop;
    logic   buf_empty;
    logic   show_pixel;
    pixel_t head;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_timing (
        .clk          (clk),
        .rst          (rst),
        .pixel_active (pixel_active),
        .hsync_d      (hsync_d),
        .vsync_d      (vsync_d)
    );

    // The source only writes with a credit in hand, so the write port
    // takes the stream directly.
    pixel_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_buffer (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (px_valid),
        .wr_data (px_data),
        .rd_en   (buf_pop),
        .head    (head),
        .empty   (buf_empty)
    );

    video_ctrl #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .pixel_active   (pixel_active),
        .buf_empty      (buf_empty),
        .buf_pop        (buf_pop),
        .show_pixel     (show_pixel),
        .px_credit      (px_credit),
        .underrun_count (underrun_count)
    );

    pixel_out i_out (
        .clk        (clk),
        .rst        (rst),
        .show_pixel (show_pixel),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .head       (head),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .vga_hsync  (vga_hsync),
        .vga_vsync  (vga_vsync)
    );

endmodule

// File: verilog/pixel_out.sv
`timescale 1ns/1ns

module pixel_out (
    input  logic              clk,
    input  logic              rst,
    input  logic              show_pixel,
    input  logic              hsync_d,
    input  logic              vsync_d,
    input  video_pkg::pixel_t head,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The colour and syncs leave one clock after the counter state
    // they belong to, so they stay aligned at the connector.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_r     <= 4'd0;
            vga_g     <= 4'd0;
            vga_b     <= 4'd0;
            vga_hsync <= 1'b0;
            vga_vsync <= 1'b0;
        end else begin
            if (show_pixel) begin
                vga_r <= head.r;
                vga_g <= head.g;
                vga_b <= head.b;
            end else begin
                // Blanking and underruns both come out black.
                vga_r <= 4'd0;
                vga_g <= 4'd0;
                vga_b <= 4'd0;
            end
            vga_hsync <= hsync_d;  // Active high.
            vga_vsync <= vsync_d;
        end
    end

endmodule

// File: verilog/video_ctrl.sv
`timescale 1ns/1ns

module video_ctrl #(
    parameter int BUF_DEPTH = video_pkg::DEF_BUF_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pixel_active,
    input  logic        buf_empty,
    output logic        buf_pop,
    output logic        show_pixel,
    output logic        px_credit,
    output logic [15:0] underrun_count
);

    localparam int OWED_W = $clog2(BUF_DEPTH + 1);

    logic [OWED_W-1:0] owed;
    logic [OWED_W:0]   avail;
    logic              give;
    logic              underrun_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pop decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Every active position consumes one pixel if there is one.
    assign buf_pop      = pixel_active && !buf_empty;
    assign show_pixel   = buf_pop;
    assign underrun_hit = pixel_active && buf_empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Credits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The countdown starts at the buffer depth and hands out one credit
    // per cycle. A pop adds one, so a pop that lands inside the initial
    // burst stretches the burst instead of being lost. Once the countdown
    // is spent, each pop comes back as a credit on the next cycle.
    assign avail = {1'b0, owed} + {{OWED_W{1'b0}}, buf_pop};
    assign give  = (avail != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owed      <= OWED_W'(BUF_DEPTH);
            px_credit <= 1'b0;
        end else begin
            px_credit <= give;
            owed      <= give ? OWED_W'(avail - 1'b1) : '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Underrun statistics
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            underrun_count <= '0;
        end else if (underrun_hit && (underrun_count != 16'hffff)) begin
            underrun_count <= underrun_count + 1'b1;  // Sticks at all ones.
        end
    end

endmodule

// File: verilog/pixel_buffer.sv
`timescale 1ns/1ns

module pixel_buffer #(
    parameter int BUF_DEPTH = video_pkg::DEF_BUF_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  video_pkg::pixel_t wr_data,
    input  logic              rd_en,
    output video_pkg::pixel_t head,
    output logic              empty
);

    import video_pkg::*;

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int OCC_W = $clog2(BUF_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(BUF_DEPTH - 1);

    pixel_t           mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] occ;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers wrap at the depth, which need not be a power of two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;  // Both or neither.
            endcase
        end
    end

    // Oldest entry falls through, so a pop takes it in the same cycle.
    assign head  = mem[rd_ptr];
    assign empty = (occ == '0);

endmodule

// File: verilog/video_timing.sv
`timescale 1ns/1ns

module video_timing #(
    parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = video_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
    parameter int H_BACK   = video_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = video_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
    parameter int V_BACK   = video_pkg::DEF_V_BACK
) (
    input  logic clk,
    input  logic rst,
    output logic pixel_active,
    output logic hsync_d,
    output logic vsync_d
);

    import video_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Window bounds, sized to the counters.
    localparam logic [CNT_W-1:0] H_END        = CNT_W'(H_ACTIVE);
    localparam logic [CNT_W-1:0] H_SYNC_START = CNT_W'(H_ACTIVE + H_FRONT);
    localparam logic [CNT_W-1:0] H_SYNC_END   = CNT_W'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [CNT_W-1:0] H_LAST       = CNT_W'(H_TOTAL - 1);
    localparam logic [CNT_W-1:0] V_END        = CNT_W'(V_ACTIVE);
    localparam logic [CNT_W-1:0] V_SYNC_START = CNT_W'(V_ACTIVE + V_FRONT);
    localparam logic [CNT_W-1:0] V_SYNC_END   = CNT_W'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam logic [CNT_W-1:0] V_LAST       = CNT_W'(V_TOTAL - 1);

    logic [CNT_W-1:0] h_cnt;
    logic [CNT_W-1:0] v_cnt;
    logic             h_last;
    logic             v_last;

    assign h_last = (h_cnt == H_LAST);  // Last clock of a line.
    assign v_last = (v_cnt == V_LAST);  // Last line of a frame.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decodes, registered downstream
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pixel_active = (h_cnt < H_END) && (v_cnt < V_END);
    assign hsync_d      = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
    assign vsync_d      = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);

endmodule

// File: verilog/video_pkg.sv
package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One RGB444 pixel, red in the top nibble.
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default raster timing, 640x480 at 60 Hz
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DEF_H_ACTIVE = 640;
    localparam int DEF_H_FRONT  = 16;
    localparam int DEF_H_SYNC   = 96;
    localparam int DEF_H_BACK   = 48;  // Total of 800 clocks per line.

    localparam int DEF_V_ACTIVE = 480;
    localparam int DEF_V_FRONT  = 10;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 33;  // Total of 525 lines per frame.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Number of pixels the buffer can hold. It is also the number of
    // credits handed out after reset.
    localparam int DEF_BUF_DEPTH = 8;

    // Wide enough for both raster counters at the default mode.
    localparam int CNT_W = 10;

endpackage
